// ==== postproc_defs.svh ====
// ==========================================================
// Build-time constants for the result write-back path
// Lane count, accumulator width, shift width, memory geometry
// ==========================================================
`ifndef POSTPROC_DEFS_SVH
`define POSTPROC_DEFS_SVH

// Result vector geometry
`define PP_LANES        7
`define PP_ACC_W        32

// Signed requant shift, two's complement
`define PP_SHIFT_W      8

// Output memory, depth must equal 2**PP_OMEM_AW
`define PP_OMEM_DEPTH   128
`define PP_OMEM_AW      7

`endif

// ==== postproc_pkg.sv ====
// ==========================================================
// Datapath types for the post-processing path
// Accumulator words, shift amounts, lane index, result vector
// ==========================================================
`include "postproc_defs.svh"

package postproc_pkg;

    // One accumulator lane, also used for requantized results
    typedef logic signed [`PP_ACC_W-1:0] acc_t;

    // Requant shift
    // positive shifts right with rounding, negative shifts left
    typedef logic signed [`PP_SHIFT_W-1:0] shift_t;

    // Lane counter, wide enough for PP_LANES-1
    typedef logic [$clog2(`PP_LANES)-1:0] lane_idx_t;

    // Full result vector from the matrix unit
    // Lane 0 sits in the low bits
    typedef acc_t [`PP_LANES-1:0] lane_vec_t;

endpackage

// ==== omem_pkg.sv ====
// ==========================================================
// Output memory types
// Word address and stored word
// ==========================================================
`include "postproc_defs.svh"

package omem_pkg;

    // Word address into the output memory
    // Wraps modulo PP_OMEM_DEPTH by its width alone
    typedef logic [`PP_OMEM_AW-1:0] omem_addr_t;

    // Stored word, raw bits of a requantized lane
    typedef logic [`PP_ACC_W-1:0] omem_word_t;

endpackage

// ==== word_stream_if.sv ====
// ==========================================================
// Lane stream between pipeline stages
// valid/ready handshake, lane data, target address, settings
// ==========================================================
`timescale 1ns/1ps

interface word_stream_if import postproc_pkg::*, omem_pkg::*; ();

    // Handshake, transfer on a rising edge with both high
    logic       valid;
    logic       ready;

    // Payload, held stable by the source until transfer
    acc_t       data;
    omem_addr_t addr;
    shift_t     shift;
    logic       relu_en;

    // Upstream side
    modport source (
        output valid, data, addr, shift, relu_en,
        input  ready
    );

    // Downstream side
    modport sink (
        input  valid, data, addr, shift, relu_en,
        output ready
    );

endinterface

// ==== result_capture.sv ====
// ==========================================================
// Result vector capture and lane serializer
// Takes one vector per handshake, emits one lane per cycle
// with address base + lane index
// ==========================================================
`timescale 1ns/1ps
`include "postproc_defs.svh"

module result_capture import postproc_pkg::*, omem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vec_valid,
    output logic       vec_ready,
    input  lane_vec_t  vec_data,
    input  omem_addr_t vec_base,
    input  shift_t     shift_amt,
    input  logic       relu_en,
    word_stream_if.source out
);

    localparam lane_idx_t LAST_LANE = lane_idx_t'(`PP_LANES - 1);

    // Control state
    logic      busy;
    lane_idx_t lane_idx;

    // Captured vector and its settings
    lane_vec_t  vec_q;
    omem_addr_t base_q;
    shift_t     shift_q;
    logic       relu_q;

    logic vec_take;
    logic lane_take;

    // ==========================================================
    // Handshakes
    // ==========================================================
    // Accept a new vector only once the last lane has left
    assign vec_ready = !busy;
    assign vec_take  = vec_valid && vec_ready;
    assign lane_take = out.valid && out.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            lane_idx <= '0;
        end else if (vec_take) begin
            busy     <= 1'b1;
            lane_idx <= '0;
        end else if (lane_take) begin
            // Free after the final lane transfers
            if (lane_idx == LAST_LANE) begin
                busy <= 1'b0;
            end else begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    // Payload capture at the vector transfer
    always_ff @(posedge clk) begin
        if (vec_take) begin
            vec_q   <= vec_data;
            base_q  <= vec_base;
            shift_q <= shift_amt;
            relu_q  <= relu_en;
        end
    end

    // ==========================================================
    // Lane output
    // ==========================================================
    assign out.valid   = busy;
    assign out.data    = vec_q[lane_idx];
    // Address wraps at the memory depth
    assign out.addr    = base_q + omem_addr_t'(lane_idx);
    assign out.shift   = shift_q;
    assign out.relu_en = relu_q;

    // A waiting vector keeps its payload until accepted
    a_vec_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vec_valid && !vec_ready) |=> (vec_valid && $stable(vec_data))
    );

    // Counter stays inside the vector while lanes go out
    a_lane_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> (lane_idx <= LAST_LANE)
    );

endmodule

// ==== requant_stage.sv ====
// ==========================================================
// Requantization pipeline register
// Rounding shift, optional ReLU, one-entry valid/ready stage
// ==========================================================
`timescale 1ns/1ps
`include "postproc_defs.svh"

module requant_stage import postproc_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    word_stream_if.sink   in,
    word_stream_if.source out
);

    // Stage register
    logic                   valid_q;
    acc_t                   data_q;
    logic [`PP_OMEM_AW-1:0] addr_q;

    acc_t rq_data;
    logic take;

    // Right shift rounds half up and left shift wraps
    // ReLU clamps negative results to zero
    function automatic acc_t requant(input acc_t value, input shift_t amt_s,
                                     input logic relu);
        acc_t       res;
        acc_t       bias;
        shift_t     mag;
        logic [4:0] amt;
        mag  = (amt_s < 0) ? -amt_s : amt_s;
        amt  = mag[4:0];
        // Half of the LSB being dropped
        bias = acc_t'(1) << (amt - 5'd1);
        if (amt_s > 0) begin
            res = (value + bias) >>> amt;
        end else if (amt_s < 0) begin
            res = value <<< amt;
        end else begin
            res = value;
        end
        if (relu && res[`PP_ACC_W-1]) begin
            res = '0;
        end
        return res;
    endfunction

    assign rq_data = requant(in.data, in.shift, in.relu_en);

    // ==========================================================
    // Handshake
    // ==========================================================
    // Take a lane when empty or when the held one leaves now
    assign in.ready = !valid_q || out.ready;
    assign take     = in.valid && in.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= rq_data;
            addr_q <= in.addr;
        end
    end

    assign out.valid   = valid_q;
    assign out.data    = data_q;
    assign out.addr    = addr_q;
    // Shift and ReLU are already applied to the result
    assign out.shift   = '0;
    assign out.relu_en = 1'b0;

    // Rounding logic handles magnitudes of 31 and below only
    a_shift_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        take |-> (in.shift <= 31 && in.shift >= -31)
    );

    // Held result does not change under back-pressure
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out.valid && !out.ready) |=>
            (out.valid && $stable(out.data) && $stable(out.addr))
    );

endmodule

// ==== output_memory.sv ====
// ==========================================================
// Output word memory
// Stream write port, always ready
// Registered CPU read port
// ==========================================================
`timescale 1ns/1ps
`include "postproc_defs.svh"

module output_memory import postproc_pkg::*, omem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    word_stream_if.sink wr,
    input  omem_addr_t cpu_rd_addr,
    input  logic       cpu_rd_en,
    output omem_word_t cpu_rd_data
);

    localparam int DEPTH = `PP_OMEM_DEPTH;

    // Storage, contents undefined after reset
    omem_word_t mem [DEPTH];

    logic wr_take;

    // Single-cycle write, never stalls the pipeline
    assign wr.ready = 1'b1;
    assign wr_take  = wr.valid && wr.ready;

    // ==========================================================
    // Write port
    // ==========================================================
    // Word stored at its transfer edge
    always_ff @(posedge clk) begin
        if (wr_take) begin
            mem[wr.addr] <= omem_word_t'(wr.data);
        end
    end

    // ==========================================================
    // CPU read port
    // ==========================================================
    // Data one cycle after the enable, held otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_rd_data <= '0;
        end else if (cpu_rd_en) begin
            cpu_rd_data <= mem[cpu_rd_addr];
        end
    end

endmodule

// ==== postproc_top.sv ====
// ==========================================================
// Write-back path top level
// Capture, requant and output memory joined by lane streams
// ==========================================================
`timescale 1ns/1ps

module postproc_top import postproc_pkg::*, omem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // Result vector input, one handshake per vector
    input  logic       vec_valid,
    output logic       vec_ready,
    input  lane_vec_t  vec_data,
    input  omem_addr_t vec_base,
    input  shift_t     shift_amt,
    input  logic       relu_en,

    // CPU readback of the output memory
    input  omem_addr_t cpu_rd_addr,
    input  logic       cpu_rd_en,
    output omem_word_t cpu_rd_data
);

    // Lane streams between stages
    word_stream_if cap_to_rq ();
    word_stream_if rq_to_mem ();

    // Vector in, one lane per cycle out
    result_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .vec_valid (vec_valid),
        .vec_ready (vec_ready),
        .vec_data  (vec_data),
        .vec_base  (vec_base),
        .shift_amt (shift_amt),
        .relu_en   (relu_en),
        .out       (cap_to_rq)
    );

    // Rounding shift and ReLU, one cycle
    requant_stage u_requant (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (cap_to_rq),
        .out   (rq_to_mem)
    );

    // Final results land here
    output_memory u_omem (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (rq_to_mem),
        .cpu_rd_addr (cpu_rd_addr),
        .cpu_rd_en   (cpu_rd_en),
        .cpu_rd_data (cpu_rd_data)
    );

endmodule

// ==== tb_postproc.sv ====
// ==========================================================
// Testbench for the result write-back path
// Clock, reset, vector and read drivers, reference model,
// compare tasks, directed tests and watchdog
// ==========================================================
`timescale 1ns/1ps
`include "postproc_defs.svh"

module tb_postproc import postproc_pkg::*, omem_pkg::*;;

    // About ten times the cycles the tests need
    localparam int MAX_CYCLES = 3000;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       vec_valid;
    logic       vec_ready;
    lane_vec_t  vec_data;
    omem_addr_t vec_base;
    shift_t     shift_amt;
    logic       relu_en;
    omem_addr_t cpu_rd_addr;
    logic       cpu_rd_en;
    omem_word_t cpu_rd_data;

    // Expected memory image
    acc_t exp_mem [`PP_OMEM_DEPTH];
    logic written [`PP_OMEM_DEPTH];

    int          cycle_count = 0;
    logic [31:0] rng_state = 32'd31287;

    postproc_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .vec_valid   (vec_valid),
        .vec_ready   (vec_ready),
        .vec_data    (vec_data),
        .vec_base    (vec_base),
        .shift_amt   (shift_amt),
        .relu_en     (relu_en),
        .cpu_rd_addr (cpu_rd_addr),
        .cpu_rd_en   (cpu_rd_en),
        .cpu_rd_data (cpu_rd_data)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // ==========================================================
    // Failure handling and compare tasks
    // ==========================================================
    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_word(input string name, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected 0x%h (%0d) got 0x%h (%0d)",
                     $time, name, expected, expected, actual, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %b got %b", $time, name, expected, actual);
            stop_on_failure();
        end
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            stop_on_failure();
        end
    end

    // ==========================================================
    // Reference model and random source
    // ==========================================================
    // Right shift rounds half up and left shift wraps in 32 bits
    // ReLU applied last
    function automatic acc_t expected_requant(input acc_t value, input shift_t amt,
                                              input logic relu);
        int   n;
        int   i;
        acc_t r;
        acc_t half;
        n = int'(amt);
        r = value;
        if (n > 0) begin
            half = 1;
            for (i = 1; i < n; i++) begin
                half = half * 2;
            end
            r = value + half;
            // Arithmetic shift one bit at a time with the sign bit copied in
            for (i = 0; i < n; i++) begin
                r = {r[`PP_ACC_W-1], r[`PP_ACC_W-1:1]};
            end
        end else if (n < 0) begin
            for (i = 0; i < -n; i++) begin
                r = {r[`PP_ACC_W-2:0], 1'b0};
            end
        end
        if (relu && r < 0) begin
            r = '0;
        end
        return r;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic get_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // ==========================================================
    // Drivers
    // ==========================================================
    // Offer a vector and hold it until accepted
    // Model updated at the transfer edge
    task automatic send_vector(input lane_vec_t v, input omem_addr_t base,
                               input shift_t amt, input logic relu);
        omem_addr_t a;
        int         k;
        @(posedge clk);
        vec_valid <= 1'b1;
        vec_data  <= v;
        vec_base  <= base;
        shift_amt <= amt;
        relu_en   <= relu;
        @(negedge clk);
        while (!vec_ready) begin
            @(negedge clk);
        end
        // Transfer edge
        @(posedge clk);
        vec_valid <= 1'b0;
        for (k = 0; k < `PP_LANES; k++) begin
            // Lane k lands at base + k modulo the memory depth
            a = omem_addr_t'((int'(base) + k) % `PP_OMEM_DEPTH);
            exp_mem[a] = expected_requant(v[k], amt, relu);
            written[a] = 1'b1;
        end
    endtask

    // Wait for capture to go idle and the last lane to leave requant
    task automatic wait_drain();
        @(negedge clk);
        while (!vec_ready) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // One-cycle enable with data sampled mid-cycle after the read edge
    task automatic read_word(input omem_addr_t a, output omem_word_t d);
        @(posedge clk);
        cpu_rd_en   <= 1'b1;
        cpu_rd_addr <= a;
        @(posedge clk);
        cpu_rd_en   <= 1'b0;
        @(negedge clk);
        d = cpu_rd_data;
    endtask

    task automatic check_mem(input omem_addr_t a, input acc_t expected);
        omem_word_t d;
        read_word(a, d);
        check_word($sformatf("mem[%0d]", a), expected, acc_t'(d));
    endtask

    task automatic check_addr(input omem_addr_t a);
        check_mem(a, exp_mem[a]);
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic test_reset_state();
        @(negedge clk);
        check_flag("vec_ready", 1'b1, vec_ready);
        check_word("cpu_rd_data", '0, acc_t'(cpu_rd_data));
    endtask

    // Zero shift without ReLU
    // Distinct lanes show the order
    task automatic test_passthrough();
        lane_vec_t v;
        int        k;
        for (k = 0; k < `PP_LANES; k++) begin
            v[k] = acc_t'(32'h8000_0011 ^ (k * 32'h0101_0101));
        end
        send_vector(v, 7'd10, 8'sd0, 1'b0);
        wait_drain();
        for (k = 0; k < `PP_LANES; k++) begin
            check_mem(omem_addr_t'(10 + k), v[k]);
        end
    endtask

    task automatic test_round_right();
        lane_vec_t v1;
        lane_vec_t v4;
        lane_vec_t v31;
        acc_t      exp1 [`PP_LANES];
        int        k;
        // Hand-worked shift by 1 including -3 to -1
        v1[0] = 5;
        v1[1] = -3;
        v1[2] = 6;
        v1[3] = -4;
        v1[4] = 7;
        v1[5] = 1;
        v1[6] = -1;
        exp1 = '{3, -1, 3, -2, 4, 1, 0};
        // Exact halves at shift 4
        v4[0] = 8;
        v4[1] = -8;
        v4[2] = 24;
        v4[3] = -24;
        v4[4] = 100;
        v4[5] = -100;
        v4[6] = 32'h7FFF_0000;
        // Largest shift where the bias add can wrap
        v31[0] = 32'h4000_0000;
        v31[1] = 32'h3FFF_FFFF;
        v31[2] = 32'hC000_0000;
        v31[3] = 32'hBFFF_FFFF;
        v31[4] = 32'h7FFF_FFFF;
        v31[5] = 32'h8000_0000;
        v31[6] = 0;
        send_vector(v1, 7'd20, 8'sd1, 1'b0);
        send_vector(v4, 7'd30, 8'sd4, 1'b0);
        send_vector(v31, 7'd40, 8'sd31, 1'b0);
        wait_drain();
        for (k = 0; k < `PP_LANES; k++) begin
            check_mem(omem_addr_t'(20 + k), exp1[k]);
            check_addr(omem_addr_t'(30 + k));
            check_addr(omem_addr_t'(40 + k));
        end
    endtask

    task automatic test_shift_left();
        lane_vec_t v;
        lane_vec_t w;
        int        k;
        v[0] = 1;
        v[1] = -5;
        v[2] = 32'h4000_0001;
        v[3] = 32'h7FFF_FFFF;
        v[4] = 32'h8000_0001;
        v[5] = 3;
        v[6] = -1;
        w[0] = 32'h00FF_FFFF;
        w[1] = 32'h0123_4567;
        w[2] = -1;
        w[3] = -256;
        w[4] = 32'h0080_0000;
        w[5] = 32'h8100_0000;
        w[6] = 7;
        send_vector(v, 7'd50, -8'sd1, 1'b0);
        send_vector(w, 7'd60, -8'sd8, 1'b0);
        wait_drain();
        for (k = 0; k < `PP_LANES; k++) begin
            check_addr(omem_addr_t'(50 + k));
            check_addr(omem_addr_t'(60 + k));
        end
    endtask

    // Same vector with ReLU on and then off
    task automatic test_relu();
        lane_vec_t v;
        acc_t      clamped;
        int        k;
        v[0] = -10;
        v[1] = 20;
        v[2] = 32'h8000_0000;
        v[3] = 0;
        v[4] = -1;
        v[5] = 32'h7FFF_FFFF;
        v[6] = 33;
        send_vector(v, 7'd70, 8'sd0, 1'b1);
        send_vector(v, 7'd80, 8'sd0, 1'b0);
        wait_drain();
        for (k = 0; k < `PP_LANES; k++) begin
            clamped = v[k][`PP_ACC_W-1] ? acc_t'(0) : v[k];
            check_mem(omem_addr_t'(70 + k), clamped);
            check_mem(omem_addr_t'(80 + k), v[k]);
        end
    endtask

    // Random vectors back to back with every third base near the top
    // Bases from 122 up always run past address 127
    task automatic test_random_stream();
        lane_vec_t   v;
        omem_addr_t  base;
        shift_t      amt;
        logic [31:0] r;
        int          i;
        int          k;
        for (i = 0; i < 8; i++) begin
            for (k = 0; k < `PP_LANES; k++) begin
                get_random(r);
                v[k] = acc_t'(r);
            end
            get_random(r);
            base = (i % 3 == 0) ? omem_addr_t'(122 + int'(r % 6)) : omem_addr_t'(r);
            get_random(r);
            amt = shift_t'(int'(r % 40) - 8);
            send_vector(v, base, amt, r[16]);
        end
        wait_drain();
        for (i = 0; i < `PP_OMEM_DEPTH; i++) begin
            if (written[i]) begin
                check_addr(omem_addr_t'(i));
            end
        end
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin : main
        int i;
        rst_n       = 1'b0;
        vec_valid   = 1'b0;
        vec_data    = '0;
        vec_base    = '0;
        shift_amt   = '0;
        relu_en     = 1'b0;
        cpu_rd_addr = '0;
        cpu_rd_en   = 1'b0;
        for (i = 0; i < `PP_OMEM_DEPTH; i++) begin
            exp_mem[i] = '0;
            written[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_passthrough();
        test_round_right();
        test_shift_left();
        test_relu();
        test_random_stream();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
postproc_pkg.sv
omem_pkg.sv
word_stream_if.sv
result_capture.sv
requant_stage.sv
output_memory.sv
postproc_top.sv
tb_postproc.sv

// ==== Makefile ====
# Verilator build for the write-back path testbench

VERILATOR  = verilator
TOP        = tb_postproc
FILELIST   = files.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output shown on the console, pass decided by a search for the pass message
sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
